//--- verilog/axil_pkg.sv
package axil_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Read response codes, EXOKAY has no use in AXI4-Lite
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Handshake progress of one read
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        RESP = 2'd2
    } txn_state_e;

endpackage

//--- verilog/axil_map_pkg.sv
package axil_map_pkg;

    // Default interconnect size
    localparam int DEF_NUM_MASTERS = 2;
    localparam int DEF_NUM_SLAVES  = 4;

    // Default address map, one 4 KiB window per slave
    localparam axil_pkg::addr_t DEF_SLAVE_BASE [DEF_NUM_SLAVES] = '{
        32'h0000_0000,
        32'h0000_1000,
        32'h0000_2000,
        32'h0000_3000
    };

    localparam axil_pkg::addr_t DEF_SLAVE_RANGE [DEF_NUM_SLAVES] = '{
        default: 32'h0000_1000
    };

    // Indices into the default master and slave sets
    typedef logic [$clog2(DEF_NUM_MASTERS)-1:0] mst_idx_t;
    typedef logic [$clog2(DEF_NUM_SLAVES)-1:0]  slv_idx_t;

endpackage

//--- verilog/axil_rd_if.sv
`timescale 1ns/1ps

interface axil_rd_if;

    import axil_pkg::*;

    // Read address channel
    addr_t          araddr;
    logic           arvalid;
    logic           arready;

    // Read data channel
    data_t          rdata;
    logic   [1:0]   rresp;
    logic           rvalid;
    logic           rready;

    // Side that issues reads
    modport mst (
        output araddr,
        output arvalid,
        input  arready,
        input  rdata,
        input  rresp,
        input  rvalid,
        output rready
    );

    // Side that answers reads
    modport slv (
        input  araddr,
        input  arvalid,
        output arready,
        output rdata,
        output rresp,
        output rvalid,
        input  rready
    );

endinterface

//--- verilog/axil_rd_master_port.sv
`timescale 1ns/1ps

module axil_rd_master_port #(
    parameter int               NUM_SLAVES                  = 4,
    parameter axil_pkg::addr_t  SLAVE_BASE  [NUM_SLAVES]    = '{default: '0},
    parameter axil_pkg::addr_t  SLAVE_RANGE [NUM_SLAVES]    = '{default: '0}
) (
    input  logic                    aclk,
    input  logic                    reset,
    axil_rd_if.slv                  up,
    axil_rd_if.mst                  xbar,
    axil_rd_if.mst                  err,
    output logic [NUM_SLAVES-1:0]   request
);

    import axil_pkg::*;

    txn_state_e                 state;
    logic   [NUM_SLAVES-1:0]    hit;
    logic                       miss;
    logic                       route_err;
    logic                       to_err;
    logic                       idle;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            hit[s] = (up.araddr >= SLAVE_BASE[s]) &&
                     ((up.araddr - SLAVE_BASE[s]) < SLAVE_RANGE[s]);
        end
    end

    assign idle = (state == IDLE);
    assign miss = ~|hit;

    // Live decode while idle, latched route once the address is taken
    assign to_err = idle ? miss : route_err;

    // Only a waiting address competes for a slave
    assign request = (idle && up.arvalid) ? hit : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Steering
    ////////////////////////////////////////////////////////////////////////////

    assign xbar.araddr  = up.araddr;
    assign xbar.arvalid = idle && up.arvalid && !to_err;
    assign xbar.rready  = up.rready && !to_err;

    assign err.araddr   = up.araddr;
    assign err.arvalid  = idle && up.arvalid && to_err;
    assign err.rready   = up.rready && to_err;

    // No second address accepted while a read is in flight
    assign up.arready   = idle && (to_err ? err.arready : xbar.arready);
    assign up.rvalid    = to_err ? err.rvalid : xbar.rvalid;
    assign up.rdata     = to_err ? err.rdata  : xbar.rdata;
    assign up.rresp     = to_err ? err.rresp  : xbar.rresp;

    ////////////////////////////////////////////////////////////////////////////
    // Transaction tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= IDLE;
            route_err <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (up.arvalid && up.arready) begin
                        state     <= RESP;
                        route_err <= miss;
                    end
                end
                RESP: begin
                    if (up.rvalid && up.rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/axil_rd_decerr.sv
`timescale 1ns/1ps

module axil_rd_decerr (
    input  logic    aclk,
    input  logic    reset,
    axil_rd_if.slv  port
);

    import axil_pkg::*;

    txn_state_e state;

    // Address accepted one cycle after it shows up
    assign port.arready = (state == ADDR);

    // Unmapped reads always answer with zero data
    assign port.rvalid  = (state == RESP);
    assign port.rdata   = '0;
    assign port.rresp   = DECERR;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (port.arvalid) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (port.arvalid) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    // Response held until the master takes it
                    if (port.rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/axil_rd_arbiter.sv
`timescale 1ns/1ps

module axil_rd_arbiter #(
    parameter int NUM_MASTERS = 2
) (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic [NUM_MASTERS-1:0]  request,
    output logic [NUM_MASTERS-1:0]  grant,
    input  logic                    rvalid,
    input  logic                    rready
);

    import axil_pkg::*;

    txn_state_e                 state;
    logic   [NUM_MASTERS-1:0]   pick;

    // Lowest set bit wins
    assign pick = request & (~request + NUM_MASTERS'(1));

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
            grant <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|request) begin
                        state <= RESP;
                        grant <= pick;
                    end
                end
                RESP: begin
                    // Slave owned until its read data is taken
                    if (rvalid && rready) begin
                        state <= IDLE;
                        grant <= '0;
                    end
                end
                default: begin
                    state <= IDLE;
                    grant <= '0;
                end
            endcase
        end
    end

endmodule

//--- verilog/axil_rd_crossbar.sv
`timescale 1ns/1ps

module axil_rd_crossbar #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 4
) (
    input  logic [NUM_MASTERS-1:0]  grant       [NUM_SLAVES],
    axil_rd_if.slv                  mst_side    [NUM_MASTERS],
    axil_rd_if.mst                  slv_side    [NUM_SLAVES]
);

    import axil_pkg::*;

    addr_t          mst_araddr  [NUM_MASTERS];
    logic           mst_arvalid [NUM_MASTERS];
    logic           mst_arready [NUM_MASTERS];
    data_t          mst_rdata   [NUM_MASTERS];
    logic   [1:0]   mst_rresp   [NUM_MASTERS];
    logic           mst_rvalid  [NUM_MASTERS];
    logic           mst_rready  [NUM_MASTERS];

    addr_t          slv_araddr  [NUM_SLAVES];
    logic           slv_arvalid [NUM_SLAVES];
    logic           slv_arready [NUM_SLAVES];
    data_t          slv_rdata   [NUM_SLAVES];
    logic   [1:0]   slv_rresp   [NUM_SLAVES];
    logic           slv_rvalid  [NUM_SLAVES];
    logic           slv_rready  [NUM_SLAVES];

    ////////////////////////////////////////////////////////////////////////////
    // Interface unpacking
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
        assign mst_araddr[m]        = mst_side[m].araddr;
        assign mst_arvalid[m]       = mst_side[m].arvalid;
        assign mst_rready[m]        = mst_side[m].rready;
        assign mst_side[m].arready  = mst_arready[m];
        assign mst_side[m].rdata    = mst_rdata[m];
        assign mst_side[m].rresp    = mst_rresp[m];
        assign mst_side[m].rvalid   = mst_rvalid[m];
    end

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
        assign slv_side[s].araddr   = slv_araddr[s];
        assign slv_side[s].arvalid  = slv_arvalid[s];
        assign slv_side[s].rready   = slv_rready[s];
        assign slv_arready[s]       = slv_side[s].arready;
        assign slv_rdata[s]         = slv_side[s].rdata;
        assign slv_rresp[s]         = slv_side[s].rresp;
        assign slv_rvalid[s]        = slv_side[s].rvalid;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Routing
    ////////////////////////////////////////////////////////////////////////////

    // Master to slave, AR and rready of the granted master
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            slv_araddr[s]  = '0;
            slv_arvalid[s] = 1'b0;
            slv_rready[s]  = 1'b0;
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (grant[s][m]) begin
                    slv_araddr[s]  = mst_araddr[m];
                    slv_arvalid[s] = mst_arvalid[m];
                    slv_rready[s]  = mst_rready[m];
                end
            end
        end
    end

    // Slave to master, zeros unless some slave granted this master
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            mst_arready[m] = 1'b0;
            mst_rdata[m]   = '0;
            mst_rresp[m]   = '0;
            mst_rvalid[m]  = 1'b0;
            for (int s = 0; s < NUM_SLAVES; s++) begin
                if (grant[s][m]) begin
                    mst_arready[m] = slv_arready[s];
                    mst_rdata[m]   = slv_rdata[s];
                    mst_rresp[m]   = slv_rresp[s];
                    mst_rvalid[m]  = slv_rvalid[s];
                end
            end
        end
    end

endmodule

//--- verilog/axil_rd_interconnect.sv
`timescale 1ns/1ps

module axil_rd_interconnect #(
    parameter int               NUM_MASTERS             = axil_map_pkg::DEF_NUM_MASTERS,
    parameter int               NUM_SLAVES              = axil_map_pkg::DEF_NUM_SLAVES,
    parameter axil_pkg::addr_t  SLAVE_BASE  [NUM_SLAVES] = axil_map_pkg::DEF_SLAVE_BASE,
    parameter axil_pkg::addr_t  SLAVE_RANGE [NUM_SLAVES] = axil_map_pkg::DEF_SLAVE_RANGE
) (
    input  logic                aclk,
    input  logic                reset,

    // Master ports
    input  axil_pkg::addr_t     m_araddr    [NUM_MASTERS],
    input  logic                m_arvalid   [NUM_MASTERS],
    output logic                m_arready   [NUM_MASTERS],
    output axil_pkg::data_t     m_rdata     [NUM_MASTERS],
    output logic    [1:0]       m_rresp     [NUM_MASTERS],
    output logic                m_rvalid    [NUM_MASTERS],
    input  logic                m_rready    [NUM_MASTERS],

    // Slave ports
    output axil_pkg::addr_t     s_araddr    [NUM_SLAVES],
    output logic                s_arvalid   [NUM_SLAVES],
    input  logic                s_arready   [NUM_SLAVES],
    input  axil_pkg::data_t     s_rdata     [NUM_SLAVES],
    input  logic    [1:0]       s_rresp     [NUM_SLAVES],
    input  logic                s_rvalid    [NUM_SLAVES],
    output logic                s_rready    [NUM_SLAVES]
);

    logic   [NUM_SLAVES-1:0]    request     [NUM_MASTERS];
    logic   [NUM_MASTERS-1:0]   slv_request [NUM_SLAVES];
    logic   [NUM_MASTERS-1:0]   grant       [NUM_SLAVES];

    axil_rd_if up_if   [NUM_MASTERS] ();
    axil_rd_if xbar_if [NUM_MASTERS] ();
    axil_rd_if err_if  [NUM_MASTERS] ();
    axil_rd_if slv_if  [NUM_SLAVES]  ();

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
        assign up_if[m].araddr  = m_araddr[m];
        assign up_if[m].arvalid = m_arvalid[m];
        assign up_if[m].rready  = m_rready[m];
        assign m_arready[m]     = up_if[m].arready;
        assign m_rdata[m]       = up_if[m].rdata;
        assign m_rresp[m]       = up_if[m].rresp;
        assign m_rvalid[m]      = up_if[m].rvalid;

        axil_rd_master_port #(
            .NUM_SLAVES     (NUM_SLAVES),
            .SLAVE_BASE     (SLAVE_BASE),
            .SLAVE_RANGE    (SLAVE_RANGE)
        ) u_master_port (
            .aclk           (aclk),
            .reset          (reset),
            .up             (up_if[m]),
            .xbar           (xbar_if[m]),
            .err            (err_if[m]),
            .request        (request[m])
        );

        axil_rd_decerr u_decerr (
            .aclk           (aclk),
            .reset          (reset),
            .port           (err_if[m])
        );
    end

    // Per-master requests turned into per-slave request vectors
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_req_s
        for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_req_m
            assign slv_request[s][m] = request[m][s];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration and crossbar
    ////////////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        axil_rd_arbiter #(
            .NUM_MASTERS    (NUM_MASTERS)
        ) u_arbiter (
            .aclk           (aclk),
            .reset          (reset),
            .request        (slv_request[s]),
            .grant          (grant[s]),
            .rvalid         (slv_if[s].rvalid),
            .rready         (slv_if[s].rready)
        );

        // Slave ports broken out of the crossbar interfaces
        assign s_araddr[s]      = slv_if[s].araddr;
        assign s_arvalid[s]     = slv_if[s].arvalid;
        assign s_rready[s]      = slv_if[s].rready;
        assign slv_if[s].arready = s_arready[s];
        assign slv_if[s].rdata   = s_rdata[s];
        assign slv_if[s].rresp   = s_rresp[s];
        assign slv_if[s].rvalid  = s_rvalid[s];
    end

    axil_rd_crossbar #(
        .NUM_MASTERS    (NUM_MASTERS),
        .NUM_SLAVES     (NUM_SLAVES)
    ) u_crossbar (
        .grant          (grant),
        .mst_side       (xbar_if),
        .slv_side       (slv_if)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

//--- tests/tb_slave_model.sv
`timescale 1ns/1ps

module tb_slave_model #(
    parameter axil_pkg::data_t TAG = '0
) (
    input  logic                aclk,
    input  logic                reset,
    input  axil_pkg::addr_t     araddr,
    input  logic                arvalid,
    output logic                arready,
    output axil_pkg::data_t     rdata,
    output logic    [1:0]       rresp,
    output logic                rvalid,
    input  logic                rready
);

    import axil_pkg::*;

    addr_t addr;

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
        forever begin
            @(negedge aclk);
            if (!reset && arvalid) begin
                next_cycle();
                // Random stall before the address is taken
                repeat ($urandom_range(3, 0)) begin
                    next_cycle();
                end
                arready = 1'b1;
                @(negedge aclk);
                addr = araddr;
                next_cycle();
                arready = 1'b0;

                // Random latency before read data
                repeat ($urandom_range(3, 0)) begin
                    next_cycle();
                end
                rvalid = 1'b1;
                rdata  = addr ^ TAG;
                rresp  = OKAY;
                do begin
                    @(negedge aclk);
                end while (!rready);
                next_cycle();
                rvalid = 1'b0;
                rdata  = '0;
            end
        end
    end

endmodule

//--- tests/tb_axil_rd_interconnect.sv
`timescale 1ns/1ps

module tb_axil_rd_interconnect;

    import axil_pkg::*;
    import axil_map_pkg::*;

    localparam int NUM_MASTERS      = DEF_NUM_MASTERS;
    localparam int NUM_SLAVES       = DEF_NUM_SLAVES;
    localparam int CLK_PERIOD_NS    = 4;
    localparam int RESET_CYCLES     = 8;
    localparam int STIM_LEN         = 18;
    localparam int CYCLES_PER_ENTRY = 40;
    localparam int WATCHDOG_NS      = STIM_LEN * CYCLES_PER_ENTRY * CLK_PERIOD_NS;

    // Read data from slave n is the address XOR its tag
    localparam data_t SLAVE_TAG [NUM_SLAVES] = '{
        32'hA5A5_0000,
        32'h5A5A_1111,
        32'hC3C3_2222,
        32'h3C3C_3333
    };

    typedef struct packed {
        int             mst;
        int             slave;      // -1 where the address is unmapped
        addr_t          addr;
        logic   [1:0]   resp;
        data_t          data;
        logic           paired;     // issued in the same cycle as the next entry
    } stim_t;

    localparam stim_t STIM [STIM_LEN] = '{
        // Each master to each slave
        '{0,  0, 32'h0000_0010, OKAY,   32'h0000_0010 ^ SLAVE_TAG[0], 1'b0},
        '{0,  1, 32'h0000_1124, OKAY,   32'h0000_1124 ^ SLAVE_TAG[1], 1'b0},
        '{0,  2, 32'h0000_2FFC, OKAY,   32'h0000_2FFC ^ SLAVE_TAG[2], 1'b0},
        '{0,  3, 32'h0000_3000, OKAY,   32'h0000_3000 ^ SLAVE_TAG[3], 1'b0},
        '{1,  0, 32'h0000_0FFC, OKAY,   32'h0000_0FFC ^ SLAVE_TAG[0], 1'b0},
        '{1,  1, 32'h0000_1000, OKAY,   32'h0000_1000 ^ SLAVE_TAG[1], 1'b0},
        '{1,  2, 32'h0000_2468, OKAY,   32'h0000_2468 ^ SLAVE_TAG[2], 1'b0},
        '{1,  3, 32'h0000_3ABC, OKAY,   32'h0000_3ABC ^ SLAVE_TAG[3], 1'b0},
        // Beyond the map
        '{0, -1, 32'h0000_4000, DECERR, 32'h0000_0000,                1'b0},
        '{1, -1, 32'h8000_0000, DECERR, 32'h0000_0000,                1'b0},
        // Both masters on one slave, master 0 listed first
        '{0,  1, 32'h0000_1200, OKAY,   32'h0000_1200 ^ SLAVE_TAG[1], 1'b1},
        '{1,  1, 32'h0000_1300, OKAY,   32'h0000_1300 ^ SLAVE_TAG[1], 1'b0},
        '{0,  3, 32'h0000_3010, OKAY,   32'h0000_3010 ^ SLAVE_TAG[3], 1'b1},
        '{1,  3, 32'h0000_3020, OKAY,   32'h0000_3020 ^ SLAVE_TAG[3], 1'b0},
        // Parallel reads on separate paths
        '{0,  0, 32'h0000_0040, OKAY,   32'h0000_0040 ^ SLAVE_TAG[0], 1'b1},
        '{1,  2, 32'h0000_2080, OKAY,   32'h0000_2080 ^ SLAVE_TAG[2], 1'b0},
        '{0, -1, 32'h0000_5000, DECERR, 32'h0000_0000,                1'b1},
        '{1,  3, 32'h0000_3004, OKAY,   32'h0000_3004 ^ SLAVE_TAG[3], 1'b0}
    };

    logic           aclk;
    logic           reset;

    addr_t          m_araddr    [NUM_MASTERS];
    logic           m_arvalid   [NUM_MASTERS];
    logic           m_arready   [NUM_MASTERS];
    data_t          m_rdata     [NUM_MASTERS];
    logic   [1:0]   m_rresp     [NUM_MASTERS];
    logic           m_rvalid    [NUM_MASTERS];
    logic           m_rready    [NUM_MASTERS];

    addr_t          s_araddr    [NUM_SLAVES];
    logic           s_arvalid   [NUM_SLAVES];
    logic           s_arready   [NUM_SLAVES];
    data_t          s_rdata     [NUM_SLAVES];
    logic   [1:0]   s_rresp     [NUM_SLAVES];
    logic           s_rvalid    [NUM_SLAVES];
    logic           s_rready    [NUM_SLAVES];

    addr_t          ar_log [$];
    int             arvalid_cycles;

    ////////////////////////////////////////////////////////////////////////////
    // DUT and environment
    ////////////////////////////////////////////////////////////////////////////

    tb_clock_gen #(
        .PERIOD_NS  (CLK_PERIOD_NS)
    ) u_clock_gen (
        .clk        (aclk)
    );

    axil_rd_interconnect u_axil_rd_interconnect (
        .aclk       (aclk),
        .reset      (reset),
        .m_araddr   (m_araddr),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_rdata    (m_rdata),
        .m_rresp    (m_rresp),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready)
    );

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave_model
        tb_slave_model #(
            .TAG        (SLAVE_TAG[s])
        ) u_slave_model (
            .aclk       (aclk),
            .reset      (reset),
            .araddr     (s_araddr[s]),
            .arvalid    (s_arvalid[s]),
            .arready    (s_arready[s]),
            .rdata      (s_rdata[s]),
            .rresp      (s_rresp[s]),
            .rvalid     (s_rvalid[s]),
            .rready     (s_rready[s])
        );
    end

    // Slave-side AR activity, sampled mid-cycle
    always @(negedge aclk) begin
        if (!reset) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                if (s_arvalid[s]) begin
                    arvalid_cycles++;
                end
                if (s_arvalid[s] && s_arready[s]) begin
                    ar_log.push_back(s_araddr[s]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One complete read on the master named by the entry
    task automatic run_read(input int idx);
        int             m;
        data_t          got_data;
        logic   [1:0]   got_resp;
        m = STIM[idx].mst;
        m_araddr[m]  = STIM[idx].addr;
        m_arvalid[m] = 1'b1;
        do begin
            @(negedge aclk);
        end while (!m_arready[m]);
        next_cycle();
        m_arvalid[m] = 1'b0;
        m_araddr[m]  = '0;

        // Master-side back-pressure on R
        repeat ($urandom_range(3, 0)) begin
            next_cycle();
        end
        m_rready[m] = 1'b1;
        do begin
            @(negedge aclk);
        end while (!m_rvalid[m]);
        got_data = m_rdata[m];
        got_resp = m_rresp[m];
        next_cycle();
        m_rready[m] = 1'b0;
        check_equal($sformatf("entry %0d rresp", idx), 32'(got_resp), 32'(STIM[idx].resp));
        check_equal($sformatf("entry %0d rdata", idx), got_data, STIM[idx].data);
    endtask

    // What the slaves saw during one group of entries
    task automatic check_slave_side(input int first, input int count);
        int mapped;
        mapped = 0;
        for (int k = first; k < first + count; k++) begin
            if (STIM[k].resp == OKAY) begin
                mapped++;
            end
        end
        check_equal($sformatf("entry %0d slave AR handshakes", first), ar_log.size(), mapped);
        if (mapped == 0) begin
            check_equal($sformatf("entry %0d slave arvalid cycles", first), arvalid_cycles, 0);
        end else if (count == 1) begin
            check_equal($sformatf("entry %0d slave araddr", first), ar_log[0], STIM[first].addr);
        end else if (mapped == 2 && STIM[first].slave == STIM[first + 1].slave) begin
            // Lower master index reaches the shared slave first
            check_equal($sformatf("entry %0d first araddr", first), ar_log[0], STIM[first].addr);
            check_equal($sformatf("entry %0d second araddr", first), ar_log[1],
                        STIM[first + 1].addr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        void'($urandom(32'he781));
        arvalid_cycles = 0;
        reset          = 1'b1;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_araddr[m]  = '0;
            m_arvalid[m] = 1'b0;
            m_rready[m]  = 1'b0;
        end
        repeat (RESET_CYCLES) begin
            @(posedge aclk);
        end
        #1;
        reset = 1'b0;

        i = 0;
        while (i < STIM_LEN) begin
            ar_log.delete();
            arvalid_cycles = 0;
            if (STIM[i].paired) begin
                fork
                    run_read(i);
                    run_read(i + 1);
                join
                check_slave_side(i, 2);
                i += 2;
            end else begin
                run_read(i);
                check_slave_side(i, 1);
                i += 1;
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: reads did not complete within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation timed out");
    end

endmodule

//--- verilog.f
verilog/axil_pkg.sv
verilog/axil_map_pkg.sv
verilog/axil_rd_if.sv
verilog/axil_rd_master_port.sv
verilog/axil_rd_decerr.sv
verilog/axil_rd_arbiter.sv
verilog/axil_rd_crossbar.sv
verilog/axil_rd_interconnect.sv
tests/tb_clock_gen.sv
tests/tb_slave_model.sv
tests/tb_axil_rd_interconnect.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_axil_rd_interconnect
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
